// ==== run.sh ====
#!/bin/sh
# Build and run the DRAM FIFO controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
   --top-module tb_dram_fifo_ctrl \
   -f sim.f

./obj_dir/Vtb_dram_fifo_ctrl | tee sim.log

# The log decides the result
if grep -qx "Regression passed" sim.log; then
   exit 0
fi
exit 1

// ==== sim.f ====
source/dram_fifo_geom_pkg.sv
source/dma_burst_pkg.sv
source/dma_ctrl_if.sv
source/burst_scheduler.sv
source/fifo_level_tracker.sv
source/dram_fifo_ctrl.sv
tb/dram_fifo_checker.sv
tb/tb_dram_fifo_ctrl.sv

// ==== source/burst_scheduler.sv ====
// Burst scheduler for one direction of the DRAM FIFO
// Starts full bursts on threshold and short ones on timeout, clipped at 4 KB pages

module burst_scheduler (
   input  logic                              dram_clk,
   input  logic                              input_timeout_reset,
   input  logic                              i_clear,
   input  dram_fifo_geom_pkg::fill_level_t   i_fill,        // Words waiting at the source
   input  dram_fifo_geom_pkg::fill_level_t   i_room,        // Space at the destination
   dma_ctrl_if.sched                         ctrl,
   output logic                              o_done,        // One cycle per finished burst
   output dma_burst_pkg::burst_len_t         o_done_count
);

   dma_burst_pkg::sched_state_t   state;
   dma_burst_pkg::timeout_cnt_t   timeout_cnt;
   logic                          timeout_hit;
   logic                          go_full, go_part, start;
   logic [8:0]                    page_left;     // Words to page end, minus one
   dma_burst_pkg::burst_len_t     full_len, part_len;
   dram_fifo_geom_pkg::fill_level_t   fill_m1;
   dram_fifo_geom_pkg::buf_offset_t   burst_bytes;

   ////////////////////////////////////////
   // Trigger decode
   ////////////////////////////////////////
   assign go_full = (i_room >= dram_fifo_geom_pkg::fill_level_t'(dma_burst_pkg::BURST_THRESHOLD))
                 && (i_fill >= dram_fifo_geom_pkg::fill_level_t'(dma_burst_pkg::BURST_THRESHOLD));
   assign go_part = (i_room >= dram_fifo_geom_pkg::fill_level_t'(dma_burst_pkg::BURST_THRESHOLD))
                 && timeout_hit && (i_fill != '0);   // Only with data waiting
   assign start   = (state == dma_burst_pkg::IDLE) && (go_full || go_part);

   // Inverted word index inside the page gives what is left minus one
   assign page_left = ~ctrl.addr[dram_fifo_geom_pkg::PAGE_BYTES_LOG2-1:
                                 dram_fifo_geom_pkg::WORD_BYTES_LOG2];

   // Full burst is capped by the page end and the longest burst
   assign full_len = (page_left < {1'b0, dma_burst_pkg::BURST_MAX_LEN}) ?
                     page_left[7:0] : dma_burst_pkg::BURST_MAX_LEN;

   // Partial burst takes what is there up to the full limit
   assign fill_m1  = i_fill - 1'b1;
   assign part_len = (fill_m1 < dram_fifo_geom_pkg::fill_level_t'(full_len)) ?
                     fill_m1[7:0] : full_len;

   // Bytes moved by the finished burst
   assign burst_bytes = (dram_fifo_geom_pkg::buf_offset_t'(ctrl.count) + 1'b1)
                        << dram_fifo_geom_pkg::WORD_BYTES_LOG2;

   ////////////////////////////////////////
   // Timeout counter
   ////////////////////////////////////////
   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset || i_clear) begin
         timeout_cnt <= '0;
         timeout_hit <= 1'b0;
      end else if (start) begin   // Burst leaving so the wait restarts
         timeout_cnt <= '0;
         timeout_hit <= 1'b0;
      end else if (timeout_cnt ==
                   dma_burst_pkg::timeout_cnt_t'(dma_burst_pkg::BURST_TIMEOUT)) begin
         timeout_hit <= 1'b1;     // Sticky until the burst starts
      end else if (state == dma_burst_pkg::IDLE) begin
         timeout_cnt <= timeout_cnt + (i_fill != '0);
      end
   end

   ////////////////////////////////////////
   // Request FSM
   ////////////////////////////////////////
   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset || i_clear) begin
         state           <= dma_burst_pkg::IDLE;
         ctrl.addr       <= dram_fifo_geom_pkg::BUF_BASE;
         ctrl.ctrl_valid <= 1'b0;
         o_done          <= 1'b0;
      end else begin
         case (state)
            dma_burst_pkg::IDLE: begin
               if (go_full)
                  state <= dma_burst_pkg::REQ_FULL;
               else if (go_part)
                  state <= dma_burst_pkg::REQ_PART;
            end
            dma_burst_pkg::REQ_FULL: begin
               ctrl.count      <= full_len;
               ctrl.ctrl_valid <= 1'b1;
               state           <= dma_burst_pkg::WAIT_ACCEPT;
            end
            dma_burst_pkg::REQ_PART: begin
               ctrl.count      <= part_len;
               ctrl.ctrl_valid <= 1'b1;
               state           <= dma_burst_pkg::WAIT_ACCEPT;
            end
            dma_burst_pkg::WAIT_ACCEPT: begin
               if (ctrl.ctrl_ready) begin   // Valid and ready both high
                  ctrl.ctrl_valid <= 1'b0;
                  state           <= dma_burst_pkg::WAIT_DROP;
               end
            end
            dma_burst_pkg::WAIT_DROP: begin
               if (!ctrl.ctrl_ready)
                  state <= dma_burst_pkg::WAIT_DONE;   // Engine busy with our burst
            end
            dma_burst_pkg::WAIT_DONE: begin
               if (ctrl.ctrl_ready) begin   // Burst committed
                  // Offset wraps inside the buffer while upper bits stay at base
                  ctrl.addr[dram_fifo_geom_pkg::BUF_SIZE_LOG2-1:0] <=
                     ctrl.addr[dram_fifo_geom_pkg::BUF_SIZE_LOG2-1:0] + burst_bytes;
                  o_done <= 1'b1;
                  state  <= dma_burst_pkg::SETTLE;
               end
            end
            dma_burst_pkg::SETTLE: begin
               o_done <= 1'b0;
               state  <= dma_burst_pkg::IDLE;   // Level is fresh by now
            end
            default: state <= dma_burst_pkg::IDLE;
         endcase
      end
   end

   assign o_done_count = ctrl.count;   // Held until the next request

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   // Request drops only after the engine has taken it
   a_valid_held: assert property (@(posedge dram_clk)
      disable iff (input_timeout_reset || i_clear)
      $fell(ctrl.ctrl_valid) && !$past(input_timeout_reset || i_clear)
         |-> $past(ctrl.ctrl_ready));

   // Last byte of a requested burst stays inside the start page
   a_page_clip: assert property (@(posedge dram_clk)
      disable iff (input_timeout_reset || i_clear)
      ctrl.ctrl_valid |->
         (13'(ctrl.addr[dram_fifo_geom_pkg::PAGE_BYTES_LOG2-1:0])
          + (13'(ctrl.count) << dram_fifo_geom_pkg::WORD_BYTES_LOG2) + 13'd7)
         < 13'(1 << dram_fifo_geom_pkg::PAGE_BYTES_LOG2));

   a_done_pulse: assert property (@(posedge dram_clk)
      disable iff (input_timeout_reset || i_clear)
      o_done |=> !o_done);

endmodule

// ==== source/dma_burst_pkg.sv ====
// Burst scheduling constants and types
// Thresholds, timeout and the request state machine encoding

package dma_burst_pkg;

   ////////////////////////////////////////
   // Burst sizing
   ////////////////////////////////////////
   typedef logic [7:0] burst_len_t;          // Burst length as words minus one

   localparam int unsigned BURST_THRESHOLD = 256;     // Words that make a full burst
   localparam burst_len_t  BURST_MAX_LEN   = 8'd255;  // Longest burst, coded

   ////////////////////////////////////////
   // Timeout for partial bursts
   ////////////////////////////////////////
   typedef logic [8:0] timeout_cnt_t;
   localparam int unsigned BURST_TIMEOUT = 64;  // Idle cycles with data before a short burst

   ////////////////////////////////////////
   // Scheduler FSM
   ////////////////////////////////////////
   typedef enum logic [2:0] {
      IDLE,         // Waiting for a trigger
      REQ_FULL,     // Threshold hit, size a full burst
      REQ_PART,     // Timeout hit, size a partial burst
      WAIT_ACCEPT,  // Request up, waiting for the engine
      WAIT_DROP,    // Accepted, waiting for ready to fall
      WAIT_DONE,    // Burst running, waiting for ready to rise
      SETTLE        // Let the level tracker catch up
   } sched_state_t;

endpackage

// ==== source/dma_ctrl_if.sv ====
// DMA control request channel between a burst scheduler and the DMA engine
// Ready idles high, drops after acceptance and rises again on burst completion

interface dma_ctrl_if;

   dram_fifo_geom_pkg::byte_addr_t addr;   // Start byte address of the burst
   dma_burst_pkg::burst_len_t      count;  // Words minus one
   logic                           ctrl_valid;
   logic                           ctrl_ready;

   // Scheduler side, owns the request
   modport sched (
      output addr,
      output count,
      output ctrl_valid,
      input  ctrl_ready
   );

   // Engine side, owns ready
   modport engine (
      input  addr,
      input  count,
      input  ctrl_valid,
      output ctrl_ready
   );

endinterface

// ==== source/dram_fifo_ctrl.sv ====
// DRAM FIFO burst controller top level
// Write and read schedulers sharing one buffer level tracker

module dram_fifo_ctrl (
   input  logic                              dram_clk,
   input  logic                              input_timeout_reset,
   input  logic                              i_clear,
   input  dram_fifo_geom_pkg::fill_level_t   i_input_occupied,   // Staging FIFO fill
   input  dram_fifo_geom_pkg::fill_level_t   i_output_space,     // Output FIFO room
   // Write DMA control
   output dram_fifo_geom_pkg::byte_addr_t    o_write_addr,
   output dma_burst_pkg::burst_len_t         o_write_count,
   output logic                              o_write_ctrl_valid,
   input  logic                              i_write_ctrl_ready,
   // Read DMA control
   output dram_fifo_geom_pkg::byte_addr_t    o_read_addr,
   output dma_burst_pkg::burst_len_t         o_read_count,
   output logic                              o_read_ctrl_valid,
   input  logic                              i_read_ctrl_ready,
   output dram_fifo_geom_pkg::word_level_t   o_occupied
);

   dma_ctrl_if wr_ctrl ();
   dma_ctrl_if rd_ctrl ();

   logic                              wr_done, rd_done;
   dma_burst_pkg::burst_len_t         wr_done_count, rd_done_count;
   dram_fifo_geom_pkg::word_level_t   level_occupied, level_space;

   ////////////////////////////////////////
   // Engine side to plain ports
   ////////////////////////////////////////
   assign o_write_addr       = wr_ctrl.addr;
   assign o_write_count      = wr_ctrl.count;
   assign o_write_ctrl_valid = wr_ctrl.ctrl_valid;
   assign wr_ctrl.ctrl_ready = i_write_ctrl_ready;

   assign o_read_addr        = rd_ctrl.addr;
   assign o_read_count       = rd_ctrl.count;
   assign o_read_ctrl_valid  = rd_ctrl.ctrl_valid;
   assign rd_ctrl.ctrl_ready = i_read_ctrl_ready;

   assign o_occupied = level_occupied;

   // Writes drain the staging FIFO into free DRAM space
   burst_scheduler u_write_sched (
      .dram_clk            (dram_clk),
      .input_timeout_reset (input_timeout_reset),
      .i_clear             (i_clear),
      .i_fill              (i_input_occupied),
      .i_room              (dram_fifo_geom_pkg::fill_level_t'(level_space)),
      .ctrl                (wr_ctrl),
      .o_done              (wr_done),
      .o_done_count        (wr_done_count)
   );

   // Reads move DRAM contents into the output FIFO
   burst_scheduler u_read_sched (
      .dram_clk            (dram_clk),
      .input_timeout_reset (input_timeout_reset),
      .i_clear             (i_clear),
      .i_fill              (dram_fifo_geom_pkg::fill_level_t'(level_occupied)),
      .i_room              (i_output_space),
      .ctrl                (rd_ctrl),
      .o_done              (rd_done),
      .o_done_count        (rd_done_count)
   );

   fifo_level_tracker u_level (
      .dram_clk            (dram_clk),
      .input_timeout_reset (input_timeout_reset),
      .i_clear             (i_clear),
      .i_wr_done           (wr_done),
      .i_wr_count          (wr_done_count),
      .i_rd_done           (rd_done),
      .i_rd_count          (rd_done_count),
      .o_occupied          (level_occupied),
      .o_space             (level_space)
   );

endmodule

// ==== source/dram_fifo_geom_pkg.sv ====
// DRAM buffer geometry for the stream FIFO
// Address, level and fill types shared by the schedulers and the level tracker

package dram_fifo_geom_pkg;

   ////////////////////////////////////////
   // Buffer layout in DRAM
   ////////////////////////////////////////
   localparam int unsigned BUF_SIZE_LOG2   = 16;  // 64 KB ring buffer
   localparam int unsigned WORD_BYTES_LOG2 = 3;   // 64 bit words
   localparam int unsigned PAGE_BYTES_LOG2 = 12;  // 4 KB page, bursts never cross it

   // Buffer depth in words
   localparam int unsigned BUF_WORDS = 1 << (BUF_SIZE_LOG2 - WORD_BYTES_LOG2);

   // Held back from space, the DRAM controller may reorder reads and writes
   localparam int unsigned SPACE_GUARD = 64;

   ////////////////////////////////////////
   // Types
   ////////////////////////////////////////
   typedef logic [31:0] byte_addr_t;                   // Full byte address
   typedef logic [BUF_SIZE_LOG2-1:0] buf_offset_t;     // Byte offset inside the buffer
   typedef logic [13:0] word_level_t;                  // Words held in the buffer
   typedef logic [15:0] fill_level_t;                  // Occupancy or space of an outer FIFO

   // Start of the buffer in DRAM, must be aligned to the buffer size
   localparam byte_addr_t BUF_BASE = 32'h0000_0000;

endpackage

// ==== source/fifo_level_tracker.sv ====
// Level tracker for the DRAM buffer
// Counts words held and words still free from completed bursts

module fifo_level_tracker (
   input  logic                              dram_clk,
   input  logic                              input_timeout_reset,
   input  logic                              i_clear,
   input  logic                              i_wr_done,
   input  dma_burst_pkg::burst_len_t         i_wr_count,
   input  logic                              i_rd_done,
   input  dma_burst_pkg::burst_len_t         i_rd_count,
   output dram_fifo_geom_pkg::word_level_t   o_occupied,
   output dram_fifo_geom_pkg::word_level_t   o_space
);

   dram_fifo_geom_pkg::word_level_t   wr_words, rd_words;

   // Words per finished burst, zero when no burst finished
   assign wr_words = i_wr_done ? dram_fifo_geom_pkg::word_level_t'(i_wr_count) + 1'b1 : '0;
   assign rd_words = i_rd_done ? dram_fifo_geom_pkg::word_level_t'(i_rd_count) + 1'b1 : '0;

   ////////////////////////////////////////
   // Accumulators
   ////////////////////////////////////////
   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset || i_clear) begin
         o_occupied <= '0;
         o_space    <= dram_fifo_geom_pkg::word_level_t'(dram_fifo_geom_pkg::BUF_WORDS
                                                         - dram_fifo_geom_pkg::SPACE_GUARD);
      end else begin
         o_occupied <= o_occupied + wr_words - rd_words;   // Writes fill, reads drain
         o_space    <= o_space - wr_words + rd_words;      // Mirror of occupied
      end
   end

   // Both counters move together, their sum never drifts
   a_level_sum: assert property (@(posedge dram_clk)
      disable iff (input_timeout_reset || i_clear)
      (15'(o_occupied) + 15'(o_space)) ==
      15'(dram_fifo_geom_pkg::BUF_WORDS - dram_fifo_geom_pkg::SPACE_GUARD));

endmodule

// ==== tb/dram_fifo_checker.sv ====
// Scoreboard for the DRAM FIFO burst controller
// Predicts every burst request and the buffer level and reports each test

module dram_fifo_checker (
   input  logic                              dram_clk,
   input  logic                              input_timeout_reset,
   input  dram_fifo_geom_pkg::fill_level_t   i_input_occupied,
   input  dram_fifo_geom_pkg::fill_level_t   i_output_space,
   input  dram_fifo_geom_pkg::byte_addr_t    i_write_addr,
   input  dma_burst_pkg::burst_len_t         i_write_count,
   input  logic                              i_write_valid,
   input  logic                              i_write_ready,
   input  dram_fifo_geom_pkg::byte_addr_t    i_read_addr,
   input  dma_burst_pkg::burst_len_t         i_read_count,
   input  logic                              i_read_valid,
   input  logic                              i_read_ready,
   input  dram_fifo_geom_pkg::word_level_t   i_occupied,
   input  logic                              i_test_end,    // One cycle pulse that closes a test
   input  int                                i_test_num,
   input  int                                i_faults,      // Hangs seen by the stimulus
   input  logic                              i_close,
   output int                                o_errors,
   output int                                o_checks
);

   dram_fifo_geom_pkg::byte_addr_t   addr_s [2];     // Index 0 is write and 1 is read
   dma_burst_pkg::burst_len_t        count_s [2];
   logic                             valid_s [2], ready_s [2], valid_prev [2];
   logic                             busy [2], seen_low [2];
   int   fill_now [2], room_now [2];
   int   fill_d1 [2], fill_d2 [2], room_d1 [2], room_d2 [2];   // Delayed to the FSM decisions
   int   ptr [2], words [2], wraps [2];
   int   exp_occ, errors = 0, checks = 0, tests_run = 0, tests_bad = 0, err_mark = 0;

   assign addr_s[0]   = i_write_addr;
   assign addr_s[1]   = i_read_addr;
   assign count_s[0]  = i_write_count;
   assign count_s[1]  = i_read_count;
   assign valid_s[0]  = i_write_valid;
   assign valid_s[1]  = i_read_valid;
   assign ready_s[0]  = i_write_ready;
   assign ready_s[1]  = i_read_ready;
   assign fill_now[0] = int'(i_input_occupied);
   assign fill_now[1] = int'(i_occupied);
   // Write room is the buffer minus the guard minus what is held
   assign room_now[0] = (1 << (dram_fifo_geom_pkg::BUF_SIZE_LOG2
                               - dram_fifo_geom_pkg::WORD_BYTES_LOG2))
                        - int'(dram_fifo_geom_pkg::SPACE_GUARD) - int'(i_occupied);
   assign room_now[1] = int'(i_output_space);
   assign o_errors    = errors;
   assign o_checks    = checks;

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////
   // Burst length as words minus one that stops at the page end
   function automatic int expected_count(input int ptr_b, input int fill, input bit full);
      int page_left;
      int len;
      page_left = (1 << (dram_fifo_geom_pkg::PAGE_BYTES_LOG2
                         - dram_fifo_geom_pkg::WORD_BYTES_LOG2)) - 1
                  - (ptr_b % (1 << dram_fifo_geom_pkg::PAGE_BYTES_LOG2))
                  / (1 << dram_fifo_geom_pkg::WORD_BYTES_LOG2);
      len = full ? int'(dma_burst_pkg::BURST_MAX_LEN) : fill - 1;   // Timeout takes what waits
      if (len > int'(dma_burst_pkg::BURST_MAX_LEN))
         len = int'(dma_burst_pkg::BURST_MAX_LEN);   // No burst is longer
      if (page_left < len)
         len = page_left;
      return len;
   endfunction

   function automatic string test_name(input int n);
      case (n)
         1: return "threshold bursts";
         2: return "timeout burst";
         3: return "page clipping";
         4: return "read drain";
         5: return "room gating";
         6: return "pointer wrap";
         default: return "unknown";
      endcase
   endfunction

   task automatic report_error(input string msg);
      $display("error at %0t: %s", $time, msg);
      errors = errors + 1;
   endtask

   ////////////////////////////////////////
   // Request and completion tracking
   ////////////////////////////////////////
   task automatic check_request(input int c);
      string  dir;
      int     exp_len;
      bit     full;
      dram_fifo_geom_pkg::byte_addr_t exp_addr;
      dir      = (c == 0) ? "write" : "read";
      full     = fill_d2[c] >= int'(dma_burst_pkg::BURST_THRESHOLD);   // Threshold trigger
      exp_len  = expected_count(ptr[c], fill_d1[c], full);   // Count is sized a cycle later
      exp_addr = dram_fifo_geom_pkg::BUF_BASE + ptr[c];
      checks   = checks + 4;
      if (room_d2[c] < int'(dma_burst_pkg::BURST_THRESHOLD))
         report_error($sformatf("%s request issued with room %0d", dir, room_d2[c]));
      if (fill_d2[c] == 0)
         report_error($sformatf("%s request issued with nothing waiting", dir));
      if (addr_s[c] !== exp_addr)
         report_error($sformatf("%s addr %h expected %h", dir, addr_s[c], exp_addr));
      if (count_s[c] !== 8'(exp_len))
         report_error($sformatf("%s count %0d expected %0d", dir, count_s[c], exp_len));
   endtask

   task automatic complete_burst(input int c);
      ptr[c] = ptr[c] + (words[c] << dram_fifo_geom_pkg::WORD_BYTES_LOG2);
      if (ptr[c] >= (1 << dram_fifo_geom_pkg::BUF_SIZE_LOG2)) begin   // Ring wraps to base
         ptr[c]   = ptr[c] - (1 << dram_fifo_geom_pkg::BUF_SIZE_LOG2);
         wraps[c] = wraps[c] + 1;
      end
      exp_occ     = (c == 0) ? exp_occ + words[c] : exp_occ - words[c];
      busy[c]     = 1'b0;
      seen_low[c] = 1'b0;
   endtask

   task automatic finish_test(input int n);
      string dir;
      checks = checks + 1;
      if (int'(i_occupied) != exp_occ)
         report_error($sformatf("occupied %0d expected %0d", i_occupied, exp_occ));
      // Both pointers sit where the next burst of each side will start
      for (int c = 0; c < 2; c++) begin
         dir    = (c == 0) ? "write" : "read";
         checks = checks + 1;
         if (addr_s[c] !== dram_fifo_geom_pkg::BUF_BASE + ptr[c])
            report_error($sformatf("%s pointer %h expected %h", dir, addr_s[c],
                                   dram_fifo_geom_pkg::BUF_BASE + ptr[c]));
      end
      if (n == 6 && (wraps[0] == 0 || wraps[1] == 0)) begin
         $display("pointer never wrapped: write wraps %0d, read wraps %0d",
                  wraps[0], wraps[1]);
         errors = errors + 1;
      end
      tests_run = tests_run + 1;
      if (errors + i_faults != err_mark) begin
         tests_bad = tests_bad + 1;
         $display("test %0d %s: FAIL, %0d new problems", n, test_name(n),
                  errors + i_faults - err_mark);
      end else begin
         $display("test %0d %s: ok", n, test_name(n));
      end
      err_mark = errors + i_faults;
   endtask

   always @(posedge dram_clk) begin
      if (input_timeout_reset) begin
         for (int c = 0; c < 2; c++) begin
            valid_prev[c] = 1'b0;
            busy[c]       = 1'b0;
            seen_low[c]   = 1'b0;
            ptr[c]        = 0;
            wraps[c]      = 0;
            fill_d1[c]    = 0;
            fill_d2[c]    = 0;
            room_d1[c]    = 0;
            room_d2[c]    = 0;
         end
         exp_occ = 0;
      end else begin
         for (int c = 0; c < 2; c++) begin
            if (valid_s[c] && !valid_prev[c])
               check_request(c);                       // New request on the bus
            if (busy[c] && !ready_s[c])
               seen_low[c] = 1'b1;                     // Engine took it
            else if (busy[c] && seen_low[c] && ready_s[c])
               complete_burst(c);
            else if (!busy[c] && valid_s[c] && ready_s[c]) begin
               busy[c]     = 1'b1;
               seen_low[c] = 1'b0;
               words[c]    = int'(count_s[c]) + 1;
            end
            valid_prev[c] = valid_s[c];
            fill_d2[c]    = fill_d1[c];
            fill_d1[c]    = fill_now[c];
            room_d2[c]    = room_d1[c];
            room_d1[c]    = room_now[c];
         end
         if (i_test_end)
            finish_test(i_test_num);
         if (i_close)
            $display("tests %0d, failed %0d, checks %0d, errors %0d, hangs %0d",
                     tests_run, tests_bad, checks, errors, i_faults);
      end
   end

endmodule

// ==== tb/tb_dram_fifo_ctrl.sv ====
// Testbench for the DRAM FIFO burst controller
// Drives the staging and output FIFO levels and models both DMA engines

module tb_dram_fifo_ctrl;

   localparam int WAIT_LIMIT = 50000;   // Cycles any single wait may take

   logic                              dram_clk;
   logic                              input_timeout_reset;
   logic                              i_clear;
   dram_fifo_geom_pkg::fill_level_t   i_input_occupied = '0;
   dram_fifo_geom_pkg::fill_level_t   i_output_space;
   logic                              i_write_ctrl_ready = 1'b1;   // Engines idle ready
   logic                              i_read_ctrl_ready  = 1'b1;
   dram_fifo_geom_pkg::byte_addr_t    o_write_addr, o_read_addr;
   dma_burst_pkg::burst_len_t         o_write_count, o_read_count;
   logic                              o_write_ctrl_valid, o_read_ctrl_valid;
   dram_fifo_geom_pkg::word_level_t   o_occupied;

   integer seed = 32'h0bd8_db06;
   int     load_words;                 // Words pushed into the staging FIFO this cycle
   logic   wr_busy = 1'b0, rd_busy = 1'b0;
   int     wr_delay, rd_delay;
   logic   test_end, close_run;
   int     test_num;
   int     faults = 0;
   int     errors, checks;

   dram_fifo_ctrl dut (.*);

   dram_fifo_checker chk (
      .dram_clk (dram_clk), .input_timeout_reset (input_timeout_reset),
      .i_input_occupied (i_input_occupied), .i_output_space (i_output_space),
      .i_write_addr (o_write_addr), .i_write_count (o_write_count),
      .i_write_valid (o_write_ctrl_valid), .i_write_ready (i_write_ctrl_ready),
      .i_read_addr (o_read_addr), .i_read_count (o_read_count),
      .i_read_valid (o_read_ctrl_valid), .i_read_ready (i_read_ctrl_ready),
      .i_occupied (o_occupied), .i_test_end (test_end), .i_test_num (test_num),
      .i_faults (faults), .i_close (close_run), .o_errors (errors), .o_checks (checks)
   );

   initial begin
      dram_clk = 1'b0;
      forever #4 dram_clk = ~dram_clk;
   end

   ////////////////////////////////////////
   // DMA engine models
   ////////////////////////////////////////
   always @(posedge dram_clk) begin : dma_engines
      int drained;
      drained = 0;
      if (input_timeout_reset) begin
         i_write_ctrl_ready <= 1'b1;
         i_read_ctrl_ready  <= 1'b1;
         wr_busy            <= 1'b0;
         rd_busy            <= 1'b0;
         i_input_occupied   <= '0;
      end else begin
         if (!wr_busy && o_write_ctrl_valid && i_write_ctrl_ready) begin
            i_write_ctrl_ready <= 1'b0;                      // Accepted, burst runs
            wr_busy            <= 1'b1;
            wr_delay           <= $unsigned($random(seed)) % 16;
         end else if (wr_busy && wr_delay == 0) begin
            i_write_ctrl_ready <= 1'b1;                      // Burst complete
            wr_busy            <= 1'b0;
            drained            = int'(o_write_count) + 1;    // Words gone to DRAM
         end else if (wr_busy) begin
            wr_delay <= wr_delay - 1;
         end
         i_input_occupied <= dram_fifo_geom_pkg::fill_level_t'(int'(i_input_occupied)
                                                               + load_words - drained);
         if (!rd_busy && o_read_ctrl_valid && i_read_ctrl_ready) begin
            i_read_ctrl_ready <= 1'b0;
            rd_busy           <= 1'b1;
            rd_delay          <= $unsigned($random(seed)) % 16;
         end else if (rd_busy && rd_delay == 0) begin
            i_read_ctrl_ready <= 1'b1;
            rd_busy           <= 1'b0;
         end else if (rd_busy) begin
            rd_delay <= rd_delay - 1;
         end
      end
   end

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////
   task automatic load_input(input int n);
      @(posedge dram_clk);
      load_words <= n;
      @(posedge dram_clk);
      load_words <= 0;   // Engine block has taken it
   endtask

   task automatic set_output_space(input int n);
      @(posedge dram_clk);
      i_output_space <= dram_fifo_geom_pkg::fill_level_t'(n);
   endtask

   // Both channels idle and the staging FIFO empty for a few cycles
   task automatic wait_quiet(input bit drain);
      int cycles;
      int calm;
      cycles = 0;
      calm   = 0;
      while (calm < 4 && cycles < WAIT_LIMIT) begin
         @(posedge dram_clk);
         cycles = cycles + 1;
         if (i_input_occupied == '0 && !wr_busy && !rd_busy && !o_write_ctrl_valid
             && !o_read_ctrl_valid && (!drain || o_occupied == '0))
            calm = calm + 1;
         else
            calm = 0;
      end
      if (calm < 4) begin
         $display("timeout: bursts still running after %0d cycles", cycles);
         faults = faults + 1;
      end
   endtask

   // DRAM nearly full, write side must be stalled
   task automatic wait_stall(input int level);
      int cycles;
      cycles = 0;
      while (!(int'(o_occupied) >= level && !wr_busy && !o_write_ctrl_valid)
             && cycles < WAIT_LIMIT) begin
         @(posedge dram_clk);
         cycles = cycles + 1;
      end
      if (cycles >= WAIT_LIMIT) begin
         $display("timeout: DRAM level never reached %0d words", level);
         faults = faults + 1;
      end
   endtask

   task automatic end_test(input int n);
      @(posedge dram_clk);
      test_num <= n;
      test_end <= 1'b1;
      @(posedge dram_clk);
      test_end <= 1'b0;
   endtask

   initial begin : stimulus
      input_timeout_reset = 1'b1;
      i_clear             = 1'b0;
      i_output_space      = '0;       // Reads held off at first
      load_words          = 0;
      test_end            = 1'b0;
      test_num            = 0;
      close_run           = 1'b0;
      repeat (3) @(posedge dram_clk);
      input_timeout_reset <= 1'b0;

      load_input(768);                // Three full bursts, 2 KB apart
      wait_quiet(1'b0);
      end_test(1);
      load_input(40);                 // Short burst after the timeout
      wait_quiet(1'b0);
      end_test(2);
      load_input(300);                // First burst stops at the page end
      wait_quiet(1'b0);
      end_test(3);
      set_output_space(4096);         // Reads empty the buffer
      wait_quiet(1'b1);
      end_test(4);

      set_output_space(255);          // No read with this little room
      load_input(300);
      wait_quiet(1'b0);
      repeat (200) @(posedge dram_clk);
      set_output_space(0);
      load_input(8192);               // More than the buffer holds
      wait_stall(int'(dram_fifo_geom_pkg::BUF_WORDS - dram_fifo_geom_pkg::SPACE_GUARD) - 255);
      repeat (200) @(posedge dram_clk);
      if (i_input_occupied == '0) begin
         $display("writes went on with the DRAM buffer full");
         faults = faults + 1;
      end
      set_output_space(4096);         // Draining lets writes resume
      wait_quiet(1'b1);
      end_test(5);

      load_input(512);                // Keep going past the wrap
      wait_quiet(1'b1);
      end_test(6);

      @(posedge dram_clk);
      close_run <= 1'b1;
      @(posedge dram_clk);
      close_run <= 1'b0;
      @(posedge dram_clk);
      if (errors == 0 && faults == 0 && checks > 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule
